// File: design/id_pkg.sv
// decode section shared definitions
// widths, alpha opcode and function codes, control enums and the
// packets passed between IF/ID, the decoder, the register file and ID/EX
package id_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int xlen  = 64;  // register and pc width
  localparam int nregs = 32;  // architectural integer registers

  typedef logic [4:0] reg_idx_t;
  localparam reg_idx_t zero_reg = 5'd31;  // r31, hardwired zero

  ////////////////////////////////////////
  // opcodes and function codes
  ////////////////////////////////////////
  localparam logic [5:0] op_pal   = 6'h00;
  localparam logic [5:0] op_intop = 6'h10;  // integer arithmetic
  localparam logic [5:0] op_logic = 6'h11;  // integer logical
  localparam logic [5:0] op_ldq   = 6'h29;
  localparam logic [5:0] op_stq   = 6'h2d;
  localparam logic [5:0] op_br    = 6'h30;
  localparam logic [5:0] op_beq   = 6'h39;
  localparam logic [5:0] op_bne   = 6'h3d;

  localparam logic [6:0] addq  = 7'h20;  // under op_intop
  localparam logic [6:0] subq  = 7'h29;
  localparam logic [6:0] cmpeq = 7'h2d;
  localparam logic [6:0] and_f = 7'h00;  // under op_logic
  localparam logic [6:0] bis   = 7'h20;  // logical or

  localparam logic [25:0] pal_halt = 26'h0000555;

  ////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////
  // operate, register form
  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rega;
    reg_idx_t   regb;
    logic [2:0] sbz;       // should be zero
    logic       lit_flag;  // 0 here
    logic [6:0] func;
    reg_idx_t   regc;
  } op_reg_t;

  // operate, literal form, 8-bit zero-extended literal replaces regb
  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rega;
    logic [7:0] lit;
    logic       lit_flag;  // 1 here
    logic [6:0] func;
    reg_idx_t   regc;
  } op_lit_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rega;
    reg_idx_t    regb;   // base
    logic [15:0] disp;
  } mem_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rega;
    logic [20:0] disp;   // longword displacement
  } br_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] func;
  } pal_t;

  // one word, five views of it
  typedef union packed {
    op_reg_t r;
    op_lit_t l;
    mem_t    m;
    br_t     b;
    pal_t    p;
  } inst_t;

  ////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////
  typedef enum logic [2:0] {alu_add, alu_sub, alu_cmpeq, alu_and, alu_or} alu_func_e;
  typedef enum logic [0:0] {opa_reg, opa_npc} opa_select_e;
  typedef enum logic [1:0] {opb_reg, opb_lit, opb_mem_disp, opb_br_disp} opb_select_e;

  ////////////////////////////////////////
  // packets
  ////////////////////////////////////////
  typedef struct packed {
    logic            wr_en;
    reg_idx_t        wr_idx;
    logic [xlen-1:0] wr_data;
  } wb_reg_packet_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] npc;
    inst_t           inst;
  } if_id_packet_t;

  typedef struct packed {
    opa_select_e opa_select;
    opb_select_e opb_select;
    alu_func_e   alu_func;
    logic        rd_mem, wr_mem;
    logic        cond_branch, uncond_branch;
    logic        halt, illegal, valid;
    reg_idx_t    dest_reg_idx;
  } decoder_packet_t;

  typedef struct packed {
    logic [xlen-1:0] npc;
    inst_t           inst;
    logic [xlen-1:0] rega_value, regb_value;
    opa_select_e     opa_select;
    opb_select_e     opb_select;
    alu_func_e       alu_func;
    logic            rd_mem, wr_mem;
    logic            cond_branch, uncond_branch;
    logic            halt, illegal, valid;
    reg_idx_t        dest_reg_idx;
  } id_ex_packet_t;

endpackage

// File: design/decoder.sv
// instruction decoder
// purely combinational, turns one IF/ID instruction into its control fields
`timescale 1ns/1ps

module decoder import id_pkg::*; (
  input  if_id_packet_t   inst_pkt,  // instruction from IF/ID
  output decoder_packet_t dec_pkt    // control fields
);

  inst_t inst;
  assign inst = inst_pkt.inst;

  always_comb begin
    ////////////////////////////////////////
    // defaults, also the invalid-slot result
    ////////////////////////////////////////
    dec_pkt               = '0;
    dec_pkt.opa_select    = opa_reg;
    dec_pkt.opb_select    = opb_reg;
    dec_pkt.alu_func      = alu_add;
    dec_pkt.dest_reg_idx  = zero_reg;          // no writeback unless set
    dec_pkt.valid         = inst_pkt.valid;    // valid passes straight through

    if (inst_pkt.valid) begin
      case (inst.r.opcode)
        ////////////////////////////////////////
        // operate formats
        ////////////////////////////////////////
        op_intop: begin
          // literal flag picks lit or regb for operand b
          dec_pkt.opb_select   = inst.r.lit_flag ? opb_lit : opb_reg;
          dec_pkt.dest_reg_idx = inst.r.regc;
          case (inst.r.func)
            addq:    dec_pkt.alu_func = alu_add;
            subq:    dec_pkt.alu_func = alu_sub;
            cmpeq:   dec_pkt.alu_func = alu_cmpeq;
            default: begin
              dec_pkt.illegal      = 1'b1;      // unknown arithmetic function
              dec_pkt.dest_reg_idx = zero_reg;
            end
          endcase
        end

        op_logic: begin
          dec_pkt.opb_select   = inst.r.lit_flag ? opb_lit : opb_reg;
          dec_pkt.dest_reg_idx = inst.r.regc;
          case (inst.r.func)
            and_f:   dec_pkt.alu_func = alu_and;
            bis:     dec_pkt.alu_func = alu_or;
            default: begin
              dec_pkt.illegal      = 1'b1;      // unknown logical function
              dec_pkt.dest_reg_idx = zero_reg;
            end
          endcase
        end

        ////////////////////////////////////////
        // memory format, address = regb + disp
        ////////////////////////////////////////
        op_ldq: begin
          dec_pkt.opb_select   = opb_mem_disp;
          dec_pkt.alu_func     = alu_add;
          dec_pkt.rd_mem       = 1'b1;
          dec_pkt.dest_reg_idx = inst.m.rega;   // load target
        end

        op_stq: begin
          dec_pkt.opb_select   = opb_mem_disp;
          dec_pkt.alu_func     = alu_add;
          dec_pkt.wr_mem       = 1'b1;          // rega_value is the store data
          dec_pkt.dest_reg_idx = zero_reg;
        end

        ////////////////////////////////////////
        // branch format, target = npc + disp*4
        ////////////////////////////////////////
        op_br: begin
          dec_pkt.opa_select    = opa_npc;
          dec_pkt.opb_select    = opb_br_disp;
          dec_pkt.alu_func      = alu_add;
          dec_pkt.uncond_branch = 1'b1;
          dec_pkt.dest_reg_idx  = inst.b.rega;  // link register gets npc
        end

        op_beq, op_bne: begin
          dec_pkt.opa_select   = opa_npc;
          dec_pkt.opb_select   = opb_br_disp;
          dec_pkt.alu_func     = alu_add;
          dec_pkt.cond_branch  = 1'b1;          // condition tested on rega later
          dec_pkt.dest_reg_idx = zero_reg;
        end

        ////////////////////////////////////////
        // pal calls, only halt is supported
        ////////////////////////////////////////
        op_pal: begin
          if (inst.p.func == pal_halt) begin
            dec_pkt.halt = 1'b1;
          end else begin
            dec_pkt.illegal = 1'b1;
          end
        end

        default: begin
          dec_pkt.illegal = 1'b1;  // fp, jumps, anything not listed
        end
      endcase
    end
  end

endmodule

// File: design/regfile.sv
// integer register file, 32 x 64
// two async read ports and one write port, r31 reads zero,
// a same-cycle write is forwarded to the read ports
`timescale 1ns/1ps

module regfile import id_pkg::*; (
  input  logic            clock,
  input  reg_idx_t        rda_idx,  // read port a
  input  reg_idx_t        rdb_idx,  // read port b
  output logic [xlen-1:0] rda_out,
  output logic [xlen-1:0] rdb_out,
  input  wb_reg_packet_t  wr        // write port from writeback
);

  // r0..r30 only, r31 has no storage
  logic [xlen-1:0] regs [0:nregs-2];

  // write strobe, r31 writes are dropped
  logic wr_hit;
  assign wr_hit = wr.wr_en && (wr.wr_idx != zero_reg);

  // one read port, zero reg first then bypass then array
  function automatic logic [xlen-1:0] read_port(input reg_idx_t idx);
    logic [xlen-1:0] val;
    if (idx == zero_reg) begin
      val = '0;
    end else if (wr_hit && (wr.wr_idx == idx)) begin
      val = wr.wr_data;              // forward new data
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  // re-evaluates on index, write port and array changes alike
  always_comb begin
    rda_out = read_port(rda_idx);
    rdb_out = read_port(rdb_idx);
  end

  ////////////////////////////////////////
  // write, lands at the clock edge
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (wr_hit) begin
      regs[wr.wr_idx] <= wr.wr_data;
    end
  end

endmodule

// File: design/id_stage.sv
// instruction decode stage
// decoder and register file side by side, merged into one ID/EX packet
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  if_id_packet_t  if_id_pkt,  // from IF/ID
  input  wb_reg_packet_t wb_pkt,     // writeback write
  input  logic           clock,
  output id_ex_packet_t  id_pkt      // to ID/EX register
);

  decoder_packet_t dec_pkt;
  reg_idx_t        ra_idx, rb_idx;
  logic [xlen-1:0] ra_val, rb_val;

  // source indices come straight from the operate/memory fields
  assign ra_idx = if_id_pkt.inst.r.rega;
  assign rb_idx = if_id_pkt.inst.r.regb;

  decoder u_decoder (
    .inst_pkt (if_id_pkt),
    .dec_pkt  (dec_pkt)
  );

  regfile u_regfile (
    .clock    (clock),
    .rda_idx  (ra_idx),
    .rdb_idx  (rb_idx),
    .rda_out  (ra_val),
    .rdb_out  (rb_val),
    .wr       (wb_pkt)
  );

  ////////////////////////////////////////
  // packet assembly
  ////////////////////////////////////////
  assign id_pkt.npc           = if_id_pkt.npc;
  assign id_pkt.inst          = if_id_pkt.inst;
  assign id_pkt.rega_value    = ra_val;
  assign id_pkt.regb_value    = rb_val;  // unused by literal forms, passed anyway
  assign id_pkt.opa_select    = dec_pkt.opa_select;
  assign id_pkt.opb_select    = dec_pkt.opb_select;
  assign id_pkt.alu_func      = dec_pkt.alu_func;
  assign id_pkt.rd_mem        = dec_pkt.rd_mem;
  assign id_pkt.wr_mem        = dec_pkt.wr_mem;
  assign id_pkt.cond_branch   = dec_pkt.cond_branch;
  assign id_pkt.uncond_branch = dec_pkt.uncond_branch;
  assign id_pkt.halt          = dec_pkt.halt;
  assign id_pkt.illegal       = dec_pkt.illegal;
  assign id_pkt.valid         = dec_pkt.valid;
  assign id_pkt.dest_reg_idx  = dec_pkt.dest_reg_idx;

endmodule

// File: design/id_ex_reg.sv
// ID/EX pipeline register
// reset clears, flush loads a bubble, stall holds the current packet
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
  input  logic          clock,
  input  logic          rst_n,   // sync, active low
  input  logic          stall,   // hold contents
  input  logic          flush,   // load all-zero bubble
  input  id_ex_packet_t d,
  output id_ex_packet_t q
);

  ////////////////////////////////////////
  // priority: reset, flush, stall, load
  ////////////////////////////////////////
  // an all-zero packet decodes as a harmless bubble:
  // valid low, no memory or branch, opa_reg / opb_reg / alu_add
  // dest r0 is never acted on because valid is low

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      q <= '0;                 // clears control and payload alike
    end else if (flush) begin
      q <= '0;                 // flush beats stall
    end else if (!stall) begin
      q <= d;                  // normal advance
    end
    // stall with no flush keeps q
  end

endmodule

// File: design/decode_top.sv
// decode section top
// ID stage feeding the ID/EX register, one cycle input to output
`timescale 1ns/1ps

module decode_top import id_pkg::*; (
  input  logic           clock,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           flush,
  input  if_id_packet_t  if_id_packet,   // held in IF/ID
  input  wb_reg_packet_t wb_reg_packet,  // writeback write
  output id_ex_packet_t  id_ex_packet    // registered result
);

  id_ex_packet_t id_pkt;  // combinational packet, same cycle as inputs

  id_stage u_id_stage (
    .if_id_pkt (if_id_packet),
    .wb_pkt    (wb_reg_packet),
    .clock     (clock),
    .id_pkt    (id_pkt)
  );

  id_ex_reg u_id_ex_reg (
    .clock (clock),
    .rst_n (rst_n),
    .stall (stall),
    .flush (flush),
    .d     (id_pkt),
    .q     (id_ex_packet)
  );

endmodule

// File: bench/decode_tb.sv
// decode section testbench
// drives decode_top with directed and random instructions, keeps a shadow
// register file and checks each ID/EX packet against a predicted packet
`timescale 1ns/1ps

module decode_tb import id_pkg::*; ();

  logic           clock;
  logic           rst_n;
  logic           stall;
  logic           flush;
  if_id_packet_t  if_id_packet;
  wb_reg_packet_t wb_reg_packet;
  id_ex_packet_t  id_ex_packet;

  id_ex_packet_t   exp_pkt;                  // predicted id_ex_packet
  logic [xlen-1:0] shadow [0:30];            // model copy of r0..r30
  logic            check_en = 1'b0;          // checks off until reset is done
  logic [xlen-1:0] pc;
  int              error_count = 0;
  int              check_count = 0;
  int              cycle_count = 0;

  localparam int          max_cycles = 600;           // about twice the stimulus
  localparam logic [31:0] idle_word  = 32'hffff_ffff; // r31 sources, unused opcode

  decode_top u_decode_top (
    .clock         (clock),
    .rst_n         (rst_n),
    .stall         (stall),
    .flush         (flush),
    .if_id_packet  (if_id_packet),
    .wb_reg_packet (wb_reg_packet),
    .id_ex_packet  (id_ex_packet)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // register read as the architecture defines it
  function automatic logic [xlen-1:0] ref_read(input logic [4:0] idx,
                                               input wb_reg_packet_t w);
    if (idx == 5'd31) return '0;                          // r31 is always zero
    if (w.wr_en && (w.wr_idx == idx)) return w.wr_data;   // same-cycle write
    return shadow[idx];
  endfunction

  // packet the decode stage should build from one set of inputs
  function automatic id_ex_packet_t predict(input if_id_packet_t p,
                                            input wb_reg_packet_t w);
    id_ex_packet_t e;
    logic [31:0]   word;
    logic [5:0]    opc;
    logic [6:0]    fn;
    word           = p.inst;
    opc            = word[31:26];
    fn             = word[11:5];
    e              = '0;
    e.npc          = p.npc;
    e.inst         = p.inst;
    e.rega_value   = ref_read(word[25:21], w);
    e.regb_value   = ref_read(word[20:16], w);
    e.opa_select   = opa_reg;
    e.opb_select   = opb_reg;
    e.alu_func     = alu_add;
    e.dest_reg_idx = 5'd31;
    e.valid        = p.valid;
    if (p.valid) begin
      if (opc == op_intop || opc == op_logic) begin
        if (word[12]) e.opb_select = opb_lit;             // literal form
        e.dest_reg_idx = word[4:0];                       // regc
        if (opc == op_intop) begin
          if (fn == subq) e.alu_func = alu_sub;
          else if (fn == cmpeq) e.alu_func = alu_cmpeq;
        end else if (fn == bis) begin
          e.alu_func = alu_or;
        end else begin
          e.alu_func = alu_and;
        end
      end else if (opc == op_ldq || opc == op_stq) begin
        e.opb_select = opb_mem_disp;                      // base + disp
        e.rd_mem     = (opc == op_ldq);
        e.wr_mem     = (opc == op_stq);
        if (opc == op_ldq) e.dest_reg_idx = word[25:21];
      end else if (opc == op_br || opc == op_beq || opc == op_bne) begin
        e.opa_select    = opa_npc;
        e.opb_select    = opb_br_disp;
        e.uncond_branch = (opc == op_br);
        e.cond_branch   = (opc != op_br);
        if (opc == op_br) e.dest_reg_idx = word[25:21];   // link reg
      end else if (opc == op_pal && word[25:0] == pal_halt) begin
        e.halt = 1'b1;
      end else begin
        e.illegal = 1'b1;
      end
    end
    return e;
  endfunction

  always @(posedge clock) begin : ref_model
    if (!rst_n || flush) exp_pkt <= '0;                   // reset or bubble
    else if (!stall) exp_pkt <= predict(if_id_packet, wb_reg_packet);
    if (wb_reg_packet.wr_en && wb_reg_packet.wr_idx != 5'd31)
      shadow[wb_reg_packet.wr_idx] <= wb_reg_packet.wr_data;
  end

  ////////////////////////////////////////
  // checks, sampled mid-cycle
  ////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    error_count++;
    $display("MISMATCH %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
  endtask

  always @(negedge clock) if (check_en) check_count <= check_count + 1;

  a_npc: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.npc == exp_pkt.npc)
    else report_mismatch("npc", exp_pkt.npc, id_ex_packet.npc);
  a_inst: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.inst == exp_pkt.inst)
    else report_mismatch("inst", 64'(exp_pkt.inst), 64'(id_ex_packet.inst));
  a_rega: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.rega_value == exp_pkt.rega_value)
    else report_mismatch("rega_value", exp_pkt.rega_value, id_ex_packet.rega_value);
  a_regb: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.regb_value == exp_pkt.regb_value)
    else report_mismatch("regb_value", exp_pkt.regb_value, id_ex_packet.regb_value);
  a_opa: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.opa_select == exp_pkt.opa_select)
    else report_mismatch("opa_select", 64'(exp_pkt.opa_select), 64'(id_ex_packet.opa_select));
  a_opb: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.opb_select == exp_pkt.opb_select)
    else report_mismatch("opb_select", 64'(exp_pkt.opb_select), 64'(id_ex_packet.opb_select));
  a_alu: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.alu_func == exp_pkt.alu_func)
    else report_mismatch("alu_func", 64'(exp_pkt.alu_func), 64'(id_ex_packet.alu_func));
  a_rd: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.rd_mem == exp_pkt.rd_mem)
    else report_mismatch("rd_mem", 64'(exp_pkt.rd_mem), 64'(id_ex_packet.rd_mem));
  a_wr: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.wr_mem == exp_pkt.wr_mem)
    else report_mismatch("wr_mem", 64'(exp_pkt.wr_mem), 64'(id_ex_packet.wr_mem));
  a_cbr: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.cond_branch == exp_pkt.cond_branch)
    else report_mismatch("cond_branch", 64'(exp_pkt.cond_branch),
                         64'(id_ex_packet.cond_branch));
  a_ubr: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.uncond_branch == exp_pkt.uncond_branch)
    else report_mismatch("uncond_branch", 64'(exp_pkt.uncond_branch),
                         64'(id_ex_packet.uncond_branch));
  a_halt: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.halt == exp_pkt.halt)
    else report_mismatch("halt", 64'(exp_pkt.halt), 64'(id_ex_packet.halt));
  a_ill: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.illegal == exp_pkt.illegal)
    else report_mismatch("illegal", 64'(exp_pkt.illegal), 64'(id_ex_packet.illegal));
  a_valid: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.valid == exp_pkt.valid)
    else report_mismatch("valid", 64'(exp_pkt.valid), 64'(id_ex_packet.valid));
  a_dest: assert property (@(negedge clock) disable iff (!check_en)
      id_ex_packet.dest_reg_idx == exp_pkt.dest_reg_idx)
    else report_mismatch("dest_reg_idx", 64'(exp_pkt.dest_reg_idx),
                         64'(id_ex_packet.dest_reg_idx));

  // watchdog, ends a stuck run
  always @(posedge clock) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("closing: %0d checked cycles, %0d errors", check_count, error_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  function automatic wb_reg_packet_t make_wb(input logic en, input logic [4:0] idx,
                                             input logic [xlen-1:0] data);
    wb_reg_packet_t w;
    w.wr_en   = en;
    w.wr_idx  = idx;
    w.wr_data = data;
    return w;
  endfunction

  function automatic wb_reg_packet_t rand_wb();
    logic [31:0] r;
    r = $urandom();
    return make_wb(r[0], r[5:1], {$urandom(), $urandom()});  // any index, r31 too
  endfunction

  function automatic logic [31:0] operate_word(input logic [5:0] opc,
                                               input logic [6:0] fn, input logic lit_form);
    logic [31:0] r;
    r = $urandom();
    if (lit_form) return {opc, r[4:0], r[12:5], 1'b1, fn, r[17:13]};
    return {opc, r[4:0], r[9:5], 3'b000, 1'b0, fn, r[17:13]};
  endfunction

  function automatic logic [5:0] illegal_opcode();
    logic [31:0] r;
    logic [5:0]  opc;
    opc = op_pal;
    while (opc inside {op_pal, op_intop, op_logic, op_ldq, op_stq, op_br, op_beq, op_bne}) begin
      r   = $urandom();
      opc = r[5:0];
    end
    return opc;
  endfunction

  // one instruction of a given kind, fields random
  function automatic logic [31:0] kind_word(input int kind, input logic lit_form);
    logic [31:0] r;
    logic [31:0] word;
    r = $urandom();
    case (kind)
      0:       word = operate_word(op_intop, addq, lit_form);
      1:       word = operate_word(op_intop, subq, lit_form);
      2:       word = operate_word(op_intop, cmpeq, lit_form);
      3:       word = operate_word(op_logic, and_f, lit_form);
      4:       word = operate_word(op_logic, bis, lit_form);
      5:       word = {op_ldq, r[4:0], r[9:5], r[31:16]};
      6:       word = {op_stq, r[4:0], r[9:5], r[31:16]};
      7:       word = {op_br, r[4:0], r[31:11]};
      8:       word = {op_beq, r[4:0], r[31:11]};
      9:       word = {op_bne, r[4:0], r[31:11]};
      10:      word = {op_pal, pal_halt};
      11:      word = {op_pal, r[25:0]};              // other pal call
      12:      word = {illegal_opcode(), r[25:0]};
      default: word = idle_word;
    endcase
    return word;
  endfunction

  // drive one cycle of inputs at the rising edge
  task automatic apply(input logic v, input logic [31:0] word, input wb_reg_packet_t w);
    @(posedge clock);
    if_id_packet.valid <= v;
    if_id_packet.npc   <= pc;
    if_id_packet.inst  <= word;
    wb_reg_packet      <= w;
    pc = pc + 64'd4;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin : stimulus
    logic [31:0] r;
    logic [4:0]  idx;
    void'($urandom(3));
    rst_n              = 1'b0;
    stall              = 1'b0;
    flush              = 1'b0;
    check_en           = 1'b0;
    pc                 = 64'h1000;
    if_id_packet       = '0;
    if_id_packet.inst  = idle_word;
    wb_reg_packet      = '0;
    repeat (2) @(posedge clock);
    rst_n    <= 1'b1;
    check_en <= 1'b1;

    // fill r0..r30, no valid instruction yet
    for (int i = 0; i < 31; i++)
      apply(1'b0, idle_word, make_wb(1'b1, 5'(i), {$urandom(), $urandom()}));

    // write r31 while reading it
    r = {op_intop, 5'd31, 5'd31, 3'b000, 1'b0, addq, 5'd1};
    apply(1'b1, r, make_wb(1'b1, 5'd31, {$urandom(), $urandom()}));
    apply(1'b1, r, '0);

    // read every register back
    for (int i = 0; i < 31; i++)
      apply(1'b1, {op_intop, 5'(i), 5'(30 - i), 3'b000, 1'b0, subq, 5'(i)}, '0);

    // opcode sweep, register and literal forms
    for (int lit = 0; lit < 2; lit++)
      for (int k = 0; k < 13; k++) apply(1'b1, kind_word(k, lit[0]), rand_wb());

    // write and read of the same index in one cycle
    repeat (6) begin
      r   = $urandom();
      idx = 5'(r % 32'd31);
      apply(1'b1, {op_logic, idx, idx, 3'b000, 1'b0, bis, 5'd2},
            make_wb(1'b1, idx, {$urandom(), $urandom()}));
      apply(1'b1, {op_logic, idx, idx, 3'b000, 1'b0, bis, 5'd3}, '0);
    end

    // random mix, about one slot in eight invalid
    repeat (100) begin
      r = $urandom();
      apply(r[5:3] != 3'b000, kind_word(int'(r[31:8] % 24'd13), r[6]), rand_wb());
    end

    // stall held four cycles while the inputs keep changing
    apply(1'b1, kind_word(5, 1'b0), '0);
    stall <= 1'b1;
    repeat (4) apply(1'b1, kind_word(int'($urandom() % 32'd13), 1'b1), rand_wb());
    stall <= 1'b0;
    apply(1'b1, kind_word(7, 1'b0), '0);
    flush <= 1'b1;                                       // single bubble
    apply(1'b1, kind_word(8, 1'b0), '0);
    flush <= 1'b0;
    apply(1'b1, kind_word(0, 1'b1), '0);
    stall <= 1'b1;                                       // flush beats stall
    flush <= 1'b1;
    apply(1'b1, kind_word(6, 1'b0), '0);
    stall <= 1'b0;
    flush <= 1'b0;

    // invalid slots of every kind
    for (int k = 0; k < 13; k++) apply(1'b0, kind_word(k, 1'b0), rand_wb());

    apply(1'b0, idle_word, '0);
    repeat (3) @(posedge clock);
    if (check_count == 0) begin
      $display("no cycle was checked");
      error_count++;
    end
    $display("closing: %0d checked cycles, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/id_pkg.sv
design/decoder.sv
design/regfile.sv
design/id_stage.sv
design/id_ex_reg.sv
design/decode_top.sv
bench/decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the decode section with verilator, run decode_tb and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -j 0 --top-module decode_tb -f filelist.f -o decode_sim \
  && ./obj_dir/decode_sim 2>&1 | tee sim.log \
  || { echo "verilator build failed"; exit 1; }

[ -s sim.log ] && grep -q "TEST RESULT" sim.log \
  || { echo "simulation ended without a result"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation reported no failure"; exit 0; }
